// ==== rtl/core_shell_config.svh ====
// Core shell configuration
// Sizes of the register file and the instruction cache banks

`ifndef CORE_SHELL_CONFIG_SVH
`define CORE_SHELL_CONFIG_SVH

////////////////////////////////////////
// Register file
////////////////////////////////////////

// Integer registers, x0 included
`define CS_REG_NUM 32
`define CS_REG_W 32

////////////////////////////////////////
// Instruction cache
////////////////////////////////////////

`define CS_IC_WAYS 2
`define CS_IC_LINES 64

// 21 tag bits plus valid
`define CS_IC_TAG_W 22

// Two bus beats per line
`define CS_IC_LINE_W 64

`endif

// ==== rtl/core_shell_pkg.sv ====
// Core shell types
// Register file and icache word, index and way types

`include "core_shell_config.svh"

package core_shell_pkg;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // Register index
  typedef logic [$clog2(`CS_REG_NUM)-1:0] reg_addr_t;

  typedef logic [`CS_REG_W-1:0] reg_data_t;

  ////////////////////////////////////////
  // Instruction cache
  ////////////////////////////////////////

  // Line index, shared by tag and data banks
  typedef logic [$clog2(`CS_IC_LINES)-1:0] ic_index_t;

  // Tag bits with the valid bit on top
  typedef logic [`CS_IC_TAG_W-1:0] ic_tag_t;

  typedef logic [`CS_IC_LINE_W-1:0] ic_line_t;

  // One request bit per way
  typedef logic [`CS_IC_WAYS-1:0] ic_way_mask_t;

endpackage

// ==== rtl/core_sleep_ctrl.sv ====
// Core sleep control
// Captures fetch enable, tracks the busy flag and gates the core clock

`timescale 1ns/1ps

module core_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic fetch_enable_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o,
  output logic clk_core_o
);

  logic fetch_enable_q;
  logic core_busy_q;
  logic clock_en;
  logic clk_en_latch;

  ////////////////////////////////////////
  // Enable tracking
  ////////////////////////////////////////

  // Sticky flag set once and held until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake events act in the same cycle and busy a cycle late
  assign clock_en = fetch_enable_q &
                    (core_busy_q | debug_req_i | irq_pending_i | irq_nm_i);

  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////

  // Transparent while clk_i is low so the enable is stable over the high phase
  always_latch begin
    if (!clk_i) begin
      clk_en_latch <= clock_en | test_en_i;
    end
  end

  assign clk_core_o = clk_i & clk_en_latch;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // An unknown enable would turn the core clock unknown
  clk_en_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(clk_en_latch)
  );

endmodule

// ==== rtl/core_reg_file.sv ====
// Integer register file
// Flip-flop storage, two combinational read ports, one write port, x0 reads zero

`timescale 1ns/1ps

`include "core_shell_config.svh"

module core_reg_file import core_shell_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  reg_data_t wdata_i,
  input  logic      we_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o
);

  localparam int NumRegs = `CS_REG_NUM;

  // Only x1 and up hold state
  reg_data_t              rf_q   [1:NumRegs-1];
  reg_data_t              rf_all [NumRegs];
  logic [NumRegs-1:1]     we_dec;

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////

  always_comb begin
    for (int i = 1; i < NumRegs; i++) begin
      we_dec[i] = we_i & (waddr_i == reg_addr_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NumRegs; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NumRegs; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= wdata_i;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // x0 is hardwired to zero
  always_comb begin
    rf_all[0] = '0;
    for (int i = 1; i < NumRegs; i++) begin
      rf_all[i] = rf_q[i];
    end
  end

  assign rdata_a_o = rf_all[raddr_a_i];
  assign rdata_b_o = rf_all[raddr_b_i];

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  waddr_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(waddr_i)
  );

endmodule

// ==== rtl/ic_ram_1p.sv ====
// Single-port synchronous RAM
// Tag and data bank of one icache way, read data held until the next read

`timescale 1ns/1ps

module ic_ram_1p import core_shell_pkg::*; #(
  parameter int Width = 32,
  parameter int Depth = 64
) (
  input  logic             clk_i,
  input  logic             req_i,
  input  logic             write_i,
  input  ic_index_t        addr_i,
  input  logic [Width-1:0] wdata_i,
  output logic [Width-1:0] rdata_o
);

  logic [Width-1:0] mem [Depth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  addr_known_a: assert property (
    @(posedge clk_i)
    req_i |-> !$isunknown(addr_i)
  );

endmodule

// ==== rtl/core_shell_top.sv ====
// Core integration shell
// Sleep control with the core clock gate, register file on the gated clock
// and per-way icache tag and data banks on the free-running clock

`timescale 1ns/1ps

`include "core_shell_config.svh"

module core_shell_top import core_shell_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  // Clock gate bypass for test
  input  logic         test_en_i,

  // Core control
  input  logic         fetch_enable_i,
  input  logic         core_busy_i,
  input  logic         debug_req_i,
  input  logic         irq_pending_i,
  input  logic         irq_nm_i,
  output logic         core_sleep_o,

  // Register file
  input  reg_addr_t    rf_raddr_a_i,
  input  reg_addr_t    rf_raddr_b_i,
  input  reg_addr_t    rf_waddr_i,
  input  reg_data_t    rf_wdata_i,
  input  logic         rf_we_i,
  output reg_data_t    rf_rdata_a_o,
  output reg_data_t    rf_rdata_b_o,

  // Icache tag banks
  input  ic_way_mask_t ic_tag_req_i,
  input  logic         ic_tag_write_i,
  input  ic_index_t    ic_tag_addr_i,
  input  ic_tag_t      ic_tag_wdata_i,
  output ic_tag_t      ic_tag_rdata_o [`CS_IC_WAYS],

  // Icache data banks
  input  ic_way_mask_t ic_data_req_i,
  input  logic         ic_data_write_i,
  input  ic_index_t    ic_data_addr_i,
  input  ic_line_t     ic_data_wdata_i,
  output ic_line_t     ic_data_rdata_o [`CS_IC_WAYS]
);

  logic clk_core;

  ////////////////////////////////////////
  // Sleep control and clock gate
  ////////////////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .debug_req_i    (debug_req_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .core_sleep_o   (core_sleep_o),
    .clk_core_o     (clk_core)
  );

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // Writes only land while the core clock runs
  core_reg_file u_reg_file (
    .clk_i     (clk_core),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .waddr_i   (rf_waddr_i),
    .wdata_i   (rf_wdata_i),
    .we_i      (rf_we_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o)
  );

  ////////////////////////////////////////
  // Icache banks
  ////////////////////////////////////////

  // Ungated clock, so the cache can be filled while the core sleeps
  for (genvar way = 0; way < `CS_IC_WAYS; way++) begin : gen_ways
    ic_ram_1p #(
      .Width (`CS_IC_TAG_W),
      .Depth (`CS_IC_LINES)
    ) u_tag_bank (
      .clk_i   (clk_i),
      .req_i   (ic_tag_req_i[way]),
      .write_i (ic_tag_write_i),
      .addr_i  (ic_tag_addr_i),
      .wdata_i (ic_tag_wdata_i),
      .rdata_o (ic_tag_rdata_o[way])
    );

    ic_ram_1p #(
      .Width (`CS_IC_LINE_W),
      .Depth (`CS_IC_LINES)
    ) u_data_bank (
      .clk_i   (clk_i),
      .req_i   (ic_data_req_i[way]),
      .write_i (ic_data_write_i),
      .addr_i  (ic_data_addr_i),
      .wdata_i (ic_data_wdata_i),
      .rdata_o (ic_data_rdata_o[way])
    );
  end

endmodule

// ==== sim/tb_core_shell_tasks.svh ====
// Core shell testbench helpers
// Compare, wait, random and register file driver tasks

`ifndef TB_CORE_SHELL_TASKS_SVH
`define TB_CORE_SHELL_TASKS_SVH

////////////////////////////////////////
// Failure and compare
////////////////////////////////////////

task automatic stop_on_error();
  $display("test failed");
  $fatal(1, "Stopped at %0t on the first failing check", $time);
endtask

task automatic check_reg(input string name, input reg_data_t got, input reg_data_t expected);
  if (got !== expected) begin
    $display("Error: %s is 0x%h, expected 0x%h", name, got, expected);
    stop_on_error();
  end
endtask

task automatic check_tag(input string name, input ic_tag_t got, input ic_tag_t expected);
  if (got !== expected) begin
    $display("Error: %s is 0x%h, expected 0x%h", name, got, expected);
    stop_on_error();
  end
endtask

task automatic check_line(input string name, input ic_line_t got, input ic_line_t expected);
  if (got !== expected) begin
    $display("Error: %s is 0x%h, expected 0x%h", name, got, expected);
    stop_on_error();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
  if (got !== expected) begin
    $display("Error: %s is 0x%h, expected 0x%h", name, got, expected);
    stop_on_error();
  end
endtask

// Sleep flag at the next falling edge, inputs have settled by then
task automatic sample_sleep(input logic expected);
  @(negedge clk);
  check_bit("core_sleep_o", core_sleep, expected);
endtask

task automatic wait_for_sleep(input logic value);
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (core_sleep !== value && cycles < Timeout) begin
    @(negedge clk);
    cycles++;
  end
  if (core_sleep !== value) begin
    $display("Timeout: core_sleep_o did not reach %0b within %0d cycles", value, Timeout);
    stop_on_error();
  end
endtask

////////////////////////////////////////
// Random numbers
////////////////////////////////////////

// Right-shifting Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic [31:0] stepped;
  stepped = state >> 1;
  if (state[0]) begin
    stepped = stepped ^ 32'h8020_0003;
  end
  return stepped;
endfunction

function automatic logic [63:0] take_bits(input int count);
  logic [63:0] bits;
  bits = '0;
  for (int i = 0; i < count; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    bits[i] = lfsr_state[0];
  end
  return bits;
endfunction

// Any register but x0
function automatic reg_addr_t rand_reg();
  reg_addr_t addr;
  addr = reg_addr_t'(take_bits(5));
  if (addr == reg_addr_t'(0)) begin
    addr = reg_addr_t'(1);
  end
  return addr;
endfunction

////////////////////////////////////////
// Register file driver
////////////////////////////////////////

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
  @(posedge clk);
  rf_waddr <= addr;
  rf_wdata <= data;
  rf_we    <= 1'b1;
  @(posedge clk);
  rf_we    <= 1'b0;
endtask

task automatic read_regs(input reg_addr_t addr_a, input reg_addr_t addr_b);
  @(posedge clk);
  rf_raddr_a <= addr_a;
  rf_raddr_b <= addr_b;
  @(negedge clk);
  check_reg($sformatf("rf_rdata_a_o[x%0d]", addr_a), rf_rdata_a, rf_model[addr_a]);
  check_reg($sformatf("rf_rdata_b_o[x%0d]", addr_b), rf_rdata_b, rf_model[addr_b]);
endtask

`endif

// ==== sim/tb_core_shell.sv ====
// Core shell testbench
// Stands in for the core, drives the sleep, register file and icache ports
// and checks the responses against simple models

`timescale 1ns/1ps

`include "core_shell_config.svh"

module tb_core_shell import core_shell_pkg::*; ();

  localparam int          Timeout  = 100;
  localparam logic [31:0] LfsrSeed = 32'hacdf;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         test_en;
  logic         fetch_enable;
  logic         core_busy;
  logic         debug_req;
  logic         irq_pending;
  logic         irq_nm;
  logic         core_sleep;

  reg_addr_t    rf_raddr_a;
  reg_addr_t    rf_raddr_b;
  reg_addr_t    rf_waddr;
  reg_data_t    rf_wdata;
  logic         rf_we;
  reg_data_t    rf_rdata_a;
  reg_data_t    rf_rdata_b;

  ic_way_mask_t ic_tag_req;
  logic         ic_tag_write;
  ic_index_t    ic_tag_addr;
  ic_tag_t      ic_tag_wdata;
  ic_tag_t      ic_tag_rdata [`CS_IC_WAYS];
  ic_way_mask_t ic_data_req;
  logic         ic_data_write;
  ic_index_t    ic_data_addr;
  ic_line_t     ic_data_wdata;
  ic_line_t     ic_data_rdata [`CS_IC_WAYS];

  // Models of the register file and the icache banks
  logic [31:0]  lfsr_state = LfsrSeed;
  reg_data_t    rf_model   [`CS_REG_NUM];
  ic_tag_t      tag_model  [`CS_IC_WAYS][`CS_IC_LINES];
  ic_line_t     line_model [`CS_IC_WAYS][`CS_IC_LINES];

  always #10 clk = ~clk;

  core_shell_top dut0 (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .test_en_i       (test_en),
    .fetch_enable_i  (fetch_enable),
    .core_busy_i     (core_busy),
    .debug_req_i     (debug_req),
    .irq_pending_i   (irq_pending),
    .irq_nm_i        (irq_nm),
    .core_sleep_o    (core_sleep),
    .rf_raddr_a_i    (rf_raddr_a),
    .rf_raddr_b_i    (rf_raddr_b),
    .rf_waddr_i      (rf_waddr),
    .rf_wdata_i      (rf_wdata),
    .rf_we_i         (rf_we),
    .rf_rdata_a_o    (rf_rdata_a),
    .rf_rdata_b_o    (rf_rdata_b),
    .ic_tag_req_i    (ic_tag_req),
    .ic_tag_write_i  (ic_tag_write),
    .ic_tag_addr_i   (ic_tag_addr),
    .ic_tag_wdata_i  (ic_tag_wdata),
    .ic_tag_rdata_o  (ic_tag_rdata),
    .ic_data_req_i   (ic_data_req),
    .ic_data_write_i (ic_data_write),
    .ic_data_addr_i  (ic_data_addr),
    .ic_data_wdata_i (ic_data_wdata),
    .ic_data_rdata_o (ic_data_rdata)
  );

  `include "tb_core_shell_tasks.svh"

  ////////////////////////////////////////
  // Icache driver
  ////////////////////////////////////////

  // Tag and data of one way in the same cycle
  task automatic write_ic(input int way, input ic_index_t idx, input ic_tag_t tag,
                          input ic_line_t line);
    ic_way_mask_t mask;
    mask      = '0;
    mask[way] = 1'b1;
    @(posedge clk);
    ic_tag_req    <= mask;
    ic_tag_write  <= 1'b1;
    ic_tag_addr   <= idx;
    ic_tag_wdata  <= tag;
    ic_data_req   <= mask;
    ic_data_write <= 1'b1;
    ic_data_addr  <= idx;
    ic_data_wdata <= line;
    @(posedge clk);
    ic_tag_req    <= '0;
    ic_tag_write  <= 1'b0;
    ic_data_req   <= '0;
    ic_data_write <= 1'b0;
  endtask

  task automatic read_ic(input ic_index_t idx);
    @(posedge clk);
    ic_tag_req   <= '1;
    ic_tag_addr  <= idx;
    ic_data_req  <= '1;
    ic_data_addr <= idx;
    @(posedge clk);
    ic_tag_req   <= '0;
    ic_data_req  <= '0;
    // Address moves on, read data has to stay
    ic_tag_addr  <= ~idx;
    ic_data_addr <= ~idx;
    repeat (2) begin
      @(negedge clk);
      for (int w = 0; w < `CS_IC_WAYS; w++) begin
        check_tag($sformatf("ic_tag_rdata_o[%0d]", w), ic_tag_rdata[w],
                  tag_model[w][idx]);
        check_line($sformatf("ic_data_rdata_o[%0d]", w), ic_data_rdata[w],
                   line_model[w][idx]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    sample_sleep(1'b1);
    for (int i = 0; i < `CS_REG_NUM; i++) begin
      read_regs(reg_addr_t'(i), reg_addr_t'(`CS_REG_NUM - 1 - i));
    end
    // No wake up before fetch enable
    @(posedge clk);
    debug_req <= 1'b1;
    sample_sleep(1'b1);
    sample_sleep(1'b1);
    @(posedge clk);
    debug_req    <= 1'b0;
    fetch_enable <= 1'b1;
    @(posedge clk);
    fetch_enable <= 1'b0;
    repeat (3) begin
      sample_sleep(1'b1);
    end
    @(posedge clk);
    debug_req <= 1'b1;
    sample_sleep(1'b0);
    @(posedge clk);
    debug_req <= 1'b0;
    sample_sleep(1'b1);
  endtask

  task automatic test_sleep_tracking();
    // Busy is seen one cycle late
    @(posedge clk);
    core_busy <= 1'b1;
    sample_sleep(1'b1);
    sample_sleep(1'b0);
    @(posedge clk);
    core_busy <= 1'b0;
    sample_sleep(1'b0);
    sample_sleep(1'b1);
    @(posedge clk);
    irq_nm <= 1'b1;
    sample_sleep(1'b0);
    @(posedge clk);
    irq_nm      <= 1'b0;
    irq_pending <= 1'b1;
    sample_sleep(1'b0);
    @(posedge clk);
    irq_pending <= 1'b0;
    sample_sleep(1'b1);
  endtask

  task automatic test_reg_file();
    reg_addr_t addr;
    reg_addr_t other;
    reg_data_t data;
    @(posedge clk);
    core_busy <= 1'b1;
    wait_for_sleep(1'b0);
    for (int n = 0; n < 24; n++) begin
      addr = rand_reg();
      data = reg_data_t'(take_bits(`CS_REG_W));
      write_reg(addr, data);
      rf_model[addr] = data;
      other = reg_addr_t'(take_bits(5));
      read_regs(addr, other);
      read_regs(other, addr);
    end
    // x0 keeps reading zero, so its model entry stays zero
    write_reg(reg_addr_t'(0), reg_data_t'(take_bits(`CS_REG_W)));
    read_regs(reg_addr_t'(0), reg_addr_t'(0));
  endtask

  task automatic test_gated_writes();
    reg_addr_t addr;
    reg_data_t new_data;
    @(posedge clk);
    core_busy <= 1'b0;
    wait_for_sleep(1'b1);
    addr     = rand_reg();
    new_data = reg_data_t'(take_bits(`CS_REG_W));
    if (new_data == rf_model[addr]) begin
      new_data = ~new_data;
    end
    // Core clock is stopped, the write is dropped
    write_reg(addr, new_data);
    read_regs(addr, addr);
    @(posedge clk);
    test_en <= 1'b1;
    write_reg(addr, new_data);
    rf_model[addr] = new_data;
    read_regs(addr, addr);
    @(posedge clk);
    test_en <= 1'b0;
    sample_sleep(1'b1);
  endtask

  task automatic test_icache_banks();
    ic_index_t idx;
    ic_index_t written [$];
    int        first_way;
    int        w;
    for (int n = 0; n < 6; n++) begin
      idx       = ic_index_t'(take_bits(6));
      first_way = int'(take_bits(1));
      for (int k = 0; k < `CS_IC_WAYS; k++) begin
        w = (first_way + k) % `CS_IC_WAYS;
        tag_model[w][idx]  = ic_tag_t'(take_bits(`CS_IC_TAG_W));
        line_model[w][idx] = ic_line_t'(take_bits(`CS_IC_LINE_W));
        write_ic(w, idx, tag_model[w][idx], line_model[w][idx]);
      end
      written.push_back(idx);
    end
    foreach (written[i]) begin
      read_ic(written[i]);
    end
  endtask

  initial begin
    for (int i = 0; i < `CS_REG_NUM; i++) begin
      rf_model[i] = '0;
    end
    rst_n         <= 1'b0;
    test_en       <= 1'b0;
    fetch_enable  <= 1'b0;
    core_busy     <= 1'b0;
    debug_req     <= 1'b0;
    irq_pending   <= 1'b0;
    irq_nm        <= 1'b0;
    rf_raddr_a    <= '0;
    rf_raddr_b    <= '0;
    rf_waddr      <= '0;
    rf_wdata      <= '0;
    rf_we         <= 1'b0;
    ic_tag_req    <= '0;
    ic_tag_write  <= 1'b0;
    ic_tag_addr   <= '0;
    ic_tag_wdata  <= '0;
    ic_data_req   <= '0;
    ic_data_write <= 1'b0;
    ic_data_addr  <= '0;
    ic_data_wdata <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_sleep_tracking();
    test_reg_file();
    test_gated_writes();
    test_icache_banks();

    $display("test passed");
    $finish;
  end

endmodule

// ==== core_shell_top.f ====
+incdir+rtl
+incdir+sim
rtl/core_shell_pkg.sv
rtl/core_sleep_ctrl.sv
rtl/core_reg_file.sv
rtl/ic_ram_1p.sv
rtl/core_shell_top.sv
sim/tb_core_shell.sv

// ==== Bender.yml ====
package:
  name: core_shell

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_shell_pkg.sv
      - rtl/core_sleep_ctrl.sv
      - rtl/core_reg_file.sv
      - rtl/ic_ram_1p.sv
      - rtl/core_shell_top.sv

  - target: simulation
    include_dirs:
      - rtl
      - sim
    files:
      - sim/tb_core_shell.sv
